// File: hw/common.svh
/* Common defines for the integer execution unit
   Disables implicit nets and provides the sign extension helper */
`ifndef COMMON_SVH
`define COMMON_SVH

`default_nettype none

// Replicate bit owidth-1 of data up to nwidth bits
// data must be a plain name or select since it gets indexed
`define SIGN_EXTEND(data, owidth, nwidth) \
    {{((nwidth)-(owidth)){data[(owidth)-1]}}, data}

`endif

// File: hw/procyon_types.sv
/* Core-wide types
   Word, address and tag widths plus the opcode classes seen on issue ports */
`include "common.svh"

package procyon_types;

    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int TAG_WIDTH    = 6;
    localparam int OPCODE_WIDTH = 7;

    // Operand and result word
    typedef logic [DATA_WIDTH-1:0]  procyon_data_t;

    // Instruction address
    typedef logic [ADDR_WIDTH-1:0]  procyon_addr_t;

    // Reorder buffer tag of the destination
    typedef logic [TAG_WIDTH-1:0]   procyon_tag_t;

    // RV32I major opcodes that the integer unit accepts
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } procyon_opcode_t;

endpackage

// File: hw/ieu_pkg.sv
/* Integer execution unit types
   ALU function codes and the payloads passed between the ID and EX stages */
`include "common.svh"

package ieu_pkg;

    import procyon_types::*;

    localparam int ALU_FUNC_WIDTH = 4;
    localparam int SHAMT_WIDTH    = 5;

    // Compare functions return 0 or 1 in bit 0
    typedef enum logic [ALU_FUNC_WIDTH-1:0] {
        ALU_FUNC_ADD = 4'b0000,
        ALU_FUNC_SUB = 4'b0001,
        ALU_FUNC_AND = 4'b0010,
        ALU_FUNC_OR  = 4'b0011,
        ALU_FUNC_XOR = 4'b0100,
        ALU_FUNC_SLL = 4'b0101,
        ALU_FUNC_SRL = 4'b0110,
        ALU_FUNC_SRA = 4'b0111,
        ALU_FUNC_EQ  = 4'b1000,
        ALU_FUNC_NE  = 4'b1001,
        ALU_FUNC_LT  = 4'b1010,
        ALU_FUNC_LTU = 4'b1011,
        ALU_FUNC_GE  = 4'b1100,
        ALU_FUNC_GEU = 4'b1101
    } procyon_alu_func_t;

    typedef logic [SHAMT_WIDTH-1:0] procyon_shamt_t;

    // Decoded instruction handed from ID to EX
    typedef struct packed {
        procyon_alu_func_t  alu_func;
        procyon_data_t      src_a;
        procyon_data_t      src_b;
        procyon_addr_t      iaddr;
        procyon_data_t      imm_b;
        procyon_shamt_t     shamt;
        procyon_tag_t       tag;
        logic               pc_rel;
        logic               jmp;
        logic               br;
    } ieu_id_t;

    // Result headed for the CDB
    typedef struct packed {
        procyon_data_t      data;
        procyon_addr_t      addr;
        procyon_tag_t       tag;
        logic               redirect;
    } ieu_ex_t;

endpackage

// File: hw/ieu_stage_if.sv
/* Pipeline stage link
   Carries a valid flag and a registered payload from one stage to the next */
`timescale 1ns/1ns
`include "common.svh"

interface ieu_stage_if #(
    parameter type payload_t = logic
) (
    input logic clk
);

    logic       valid;
    payload_t   payload;

    // Producing stage
    modport src (
        output valid,
        output payload
    );

    // Consuming stage
    modport dst (
        input  valid,
        input  payload
    );

    // A valid stage output must carry a fully known payload
    payload_known: assert property (
        @(posedge clk) valid |-> !$isunknown(payload)
    );

endinterface

// File: hw/ieu_id.sv
/* IEU decode stage
   Decodes the ALU function, builds immediates and selects operands for EX */
`timescale 1ns/1ns
`include "common.svh"

module ieu_id (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_flush,
    input  procyon_types::procyon_opcode_t  i_opcode,
    input  procyon_types::procyon_data_t    i_insn,
    input  procyon_types::procyon_addr_t    i_iaddr,
    input  procyon_types::procyon_data_t    i_src_a,
    input  procyon_types::procyon_data_t    i_src_b,
    input  procyon_types::procyon_tag_t     i_tag,
    input  logic                            i_valid,
    ieu_stage_if.src                        o_id
);

    import procyon_types::*;
    import ieu_pkg::*;

    logic [2:0]         funct3;
    logic               funct7_5;
    logic [11:0]        imm_i_raw;
    logic [12:0]        imm_b_raw;
    logic [20:0]        imm_j_raw;
    procyon_data_t      imm_i;
    procyon_data_t      imm_u;
    procyon_data_t      imm_j;
    procyon_data_t      imm_b;
    procyon_alu_func_t  alu_func;
    ieu_id_t            id_next;

    assign funct3    = i_insn[14:12];
    assign funct7_5  = i_insn[30];

    // Immediate formats
    assign imm_i_raw = i_insn[31:20];
    assign imm_b_raw = {i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
    assign imm_j_raw = {i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

    assign imm_i     = `SIGN_EXTEND(imm_i_raw, 12, DATA_WIDTH);
    assign imm_b     = `SIGN_EXTEND(imm_b_raw, 13, DATA_WIDTH);
    assign imm_j     = `SIGN_EXTEND(imm_j_raw, 21, DATA_WIDTH);
    assign imm_u     = {i_insn[31:12], 12'b0};

    // ALU function from opcode class, funct3 and funct7
    always_comb begin
        alu_func = ALU_FUNC_ADD;
        case (i_opcode)
            OPCODE_OP, OPCODE_OPIMM: begin
                case (funct3)
                    3'b000: begin
                        // No SUBI, so bit 30 only matters for register ops
                        if (i_opcode == OPCODE_OP && funct7_5) begin
                            alu_func = ALU_FUNC_SUB;
                        end
                    end
                    3'b001: alu_func = ALU_FUNC_SLL;
                    3'b010: alu_func = ALU_FUNC_LT;
                    3'b011: alu_func = ALU_FUNC_LTU;
                    3'b100: alu_func = ALU_FUNC_XOR;
                    3'b101: alu_func = funct7_5 ? ALU_FUNC_SRA : ALU_FUNC_SRL;
                    3'b110: alu_func = ALU_FUNC_OR;
                    default: alu_func = ALU_FUNC_AND;
                endcase
            end
            OPCODE_BRANCH: begin
                case (funct3)
                    3'b001: alu_func = ALU_FUNC_NE;
                    3'b100: alu_func = ALU_FUNC_LT;
                    3'b101: alu_func = ALU_FUNC_GE;
                    3'b110: alu_func = ALU_FUNC_LTU;
                    3'b111: alu_func = ALU_FUNC_GEU;
                    default: alu_func = ALU_FUNC_EQ;
                endcase
            end
            default: alu_func = ALU_FUNC_ADD;
        endcase
    end

    always_comb begin
        id_next.alu_func = alu_func;
        // LUI adds its immediate to zero
        id_next.src_a    = (i_opcode == OPCODE_LUI) ? '0 : i_src_a;
        case (i_opcode)
            OPCODE_OPIMM, OPCODE_JALR: id_next.src_b = imm_i;
            OPCODE_LUI, OPCODE_AUIPC:  id_next.src_b = imm_u;
            OPCODE_JAL:                id_next.src_b = imm_j;
            default:                   id_next.src_b = i_src_b;
        endcase
        id_next.iaddr    = i_iaddr;
        id_next.imm_b    = imm_b;
        id_next.shamt    = (i_opcode == OPCODE_OPIMM) ? i_insn[20 +: SHAMT_WIDTH]
                                                      : i_src_b[SHAMT_WIDTH-1:0];
        id_next.tag      = i_tag;
        id_next.pc_rel   = (i_opcode == OPCODE_AUIPC) || (i_opcode == OPCODE_JAL);
        id_next.jmp      = (i_opcode == OPCODE_JAL) || (i_opcode == OPCODE_JALR);
        id_next.br       = (i_opcode == OPCODE_BRANCH);
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_id.valid <= 1'b0;
        end else begin
            o_id.valid <= i_valid & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        o_id.payload <= id_next;
    end

    // The reservation station only issues classes this unit executes
    issue_opcode_known: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_valid |-> i_opcode inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC,
                                     OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH}
    );

endmodule

// File: hw/ieu_ex.sv
/* IEU execute stage
   ALU, branch compare and target generation with a registered result for the CDB */
`timescale 1ns/1ns
`include "common.svh"

module ieu_ex (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        i_flush,
    ieu_stage_if.dst    i_id,
    ieu_stage_if.src    o_ex
);

    import procyon_types::*;
    import ieu_pkg::*;

    procyon_data_t          op_a;
    procyon_data_t          op_b;
    procyon_shamt_t         shamt;
    logic [DATA_WIDTH:0]    diff_s;
    logic [DATA_WIDTH:0]    diff_u;
    logic                   eq;
    logic                   lt;
    logic                   ltu;
    procyon_data_t          alu_result;
    logic                   br_taken;
    procyon_addr_t          next_iaddr;
    procyon_addr_t          br_target;
    procyon_addr_t          jmp_target;
    ieu_ex_t                ex_next;

    // AUIPC and JAL work relative to the instruction address
    assign op_a  = i_id.payload.pc_rel ? i_id.payload.iaddr : i_id.payload.src_a;
    assign op_b  = i_id.payload.src_b;
    assign shamt = i_id.payload.shamt;

    // One extra bit on each subtraction gives the compare result in the MSB
    assign diff_s = `SIGN_EXTEND(op_a, DATA_WIDTH, DATA_WIDTH+1)
                  - `SIGN_EXTEND(op_b, DATA_WIDTH, DATA_WIDTH+1);
    assign diff_u = {1'b0, op_a} - {1'b0, op_b};

    assign eq  = (op_a == op_b);
    assign lt  = diff_s[DATA_WIDTH];
    assign ltu = diff_u[DATA_WIDTH];

    always_comb begin
        case (i_id.payload.alu_func)
            ALU_FUNC_ADD: alu_result = op_a + op_b;
            ALU_FUNC_SUB: alu_result = op_a - op_b;
            ALU_FUNC_AND: alu_result = op_a & op_b;
            ALU_FUNC_OR:  alu_result = op_a | op_b;
            ALU_FUNC_XOR: alu_result = op_a ^ op_b;
            ALU_FUNC_SLL: alu_result = op_a << shamt;
            ALU_FUNC_SRL: alu_result = op_a >> shamt;
            ALU_FUNC_SRA: alu_result = procyon_data_t'($signed(op_a) >>> shamt);
            ALU_FUNC_EQ:  alu_result = DATA_WIDTH'(eq);
            ALU_FUNC_NE:  alu_result = DATA_WIDTH'(~eq);
            ALU_FUNC_LT:  alu_result = DATA_WIDTH'(lt);
            ALU_FUNC_LTU: alu_result = DATA_WIDTH'(ltu);
            ALU_FUNC_GE:  alu_result = DATA_WIDTH'(~lt);
            ALU_FUNC_GEU: alu_result = DATA_WIDTH'(~ltu);
            default:      alu_result = '0;
        endcase
    end

    assign br_taken   = i_id.payload.br & alu_result[0];
    assign next_iaddr = i_id.payload.iaddr + ADDR_WIDTH'(4);
    assign br_target  = i_id.payload.iaddr + i_id.payload.imm_b;

    // JALR drops bit 0 of its computed target, JAL keeps the sum as is
    assign jmp_target = i_id.payload.pc_rel ? alu_result
                                            : {alu_result[DATA_WIDTH-1:1], 1'b0};

    always_comb begin
        ex_next.tag = i_id.payload.tag;
        if (i_id.payload.jmp) begin
            // Link address goes back as the result
            ex_next.data     = next_iaddr;
            ex_next.addr     = jmp_target;
            ex_next.redirect = 1'b1;
        end else if (i_id.payload.br) begin
            ex_next.data     = '0;
            ex_next.addr     = br_taken ? br_target : next_iaddr;
            ex_next.redirect = br_taken;
        end else begin
            ex_next.data     = alu_result;
            ex_next.addr     = i_id.payload.iaddr;
            ex_next.redirect = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_ex.valid <= 1'b0;
        end else begin
            o_ex.valid <= i_id.valid & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        o_ex.payload <= ex_next;
    end

    // Decode never marks one instruction as both jump and branch
    jmp_br_exclusive: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_id.valid |-> !(i_id.payload.jmp && i_id.payload.br)
    );

    // A flush kills whatever EX would have produced
    flush_kills_result: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_flush |=> !o_ex.valid
    );

endmodule

// File: hw/ieu.sv
/* Integer execution unit
   Decode and execute stages in series with results driven onto the CDB */
`timescale 1ns/1ns
`include "common.svh"

module ieu (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,

    // Reservation station issue port
    input  logic                            i_fu_valid,
    input  procyon_types::procyon_opcode_t  i_fu_opcode,
    input  procyon_types::procyon_addr_t    i_fu_iaddr,
    input  procyon_types::procyon_data_t    i_fu_insn,
    input  procyon_types::procyon_data_t    i_fu_src_a,
    input  procyon_types::procyon_data_t    i_fu_src_b,
    input  procyon_types::procyon_tag_t     i_fu_tag,

    // Common data bus
    output logic                            o_cdb_en,
    output logic                            o_cdb_redirect,
    output procyon_types::procyon_data_t    o_cdb_data,
    output procyon_types::procyon_addr_t    o_cdb_addr,
    output procyon_types::procyon_tag_t     o_cdb_tag
);

    import ieu_pkg::*;

    ieu_stage_if #(.payload_t(ieu_id_t)) id_to_ex (.clk(clk));
    ieu_stage_if #(.payload_t(ieu_ex_t)) ex_to_cdb (.clk(clk));

    ieu_id ieu_id_inst (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_opcode (i_fu_opcode),
        .i_insn   (i_fu_insn),
        .i_iaddr  (i_fu_iaddr),
        .i_src_a  (i_fu_src_a),
        .i_src_b  (i_fu_src_b),
        .i_tag    (i_fu_tag),
        .i_valid  (i_fu_valid),
        .o_id     (id_to_ex.src)
    );

    ieu_ex ieu_ex_inst (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (i_flush),
        .i_id    (id_to_ex.dst),
        .o_ex    (ex_to_cdb.src)
    );

    // EX output register drives the CDB directly
    assign o_cdb_en       = ex_to_cdb.valid;
    assign o_cdb_redirect = ex_to_cdb.payload.redirect;
    assign o_cdb_data     = ex_to_cdb.payload.data;
    assign o_cdb_addr     = ex_to_cdb.payload.addr;
    assign o_cdb_tag      = ex_to_cdb.payload.tag;

    // Nothing reaches the CDB right after a reset edge
    cdb_quiet_after_reset: assert property (
        @(posedge clk) !n_rst |=> !o_cdb_en
    );

endmodule

// File: verification/ieu_tb.sv
/* Testbench for the integer execution unit
   Issues random and directed instructions and checks the CDB against a reference model */
`timescale 1ns/1ns

module ieu_tb;

    import procyon_types::*;
    import ieu_pkg::*;

    logic               clk;
    logic               n_rst;
    logic               flush;
    logic               fu_valid;
    procyon_opcode_t    fu_opcode;
    procyon_addr_t      fu_iaddr;
    procyon_data_t      fu_insn;
    procyon_data_t      fu_src_a;
    procyon_data_t      fu_src_b;
    procyon_tag_t       fu_tag;
    logic               cdb_en;
    logic               cdb_redirect;
    procyon_data_t      cdb_data;
    procyon_addr_t      cdb_addr;
    procyon_tag_t       cdb_tag;

    // Model result on the issue port and in the two stages behind it
    ieu_ex_t            cur_exp;
    ieu_ex_t            exp1;
    ieu_ex_t            exp2;
    logic               exp1_valid;
    logic               exp2_valid;

    procyon_tag_t       tag_ctr = '0;
    string              test_name = "reset";
    int                 errors = 0;
    int                 issued_count = 0;
    int                 seen_count = 0;
    int                 killed_count = 0;

    always #20 clk = ~clk;

    ieu ieu_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (flush),
        .i_fu_valid     (fu_valid),
        .i_fu_opcode    (fu_opcode),
        .i_fu_iaddr     (fu_iaddr),
        .i_fu_insn      (fu_insn),
        .i_fu_src_a     (fu_src_a),
        .i_fu_src_b     (fu_src_b),
        .i_fu_tag       (fu_tag),
        .o_cdb_en       (cdb_en),
        .o_cdb_redirect (cdb_redirect),
        .o_cdb_data     (cdb_data),
        .o_cdb_addr     (cdb_addr),
        .o_cdb_tag      (cdb_tag)
    );

    // Expected results step through the same two stages as the DUT
    always @(posedge clk) begin
        if (!n_rst) begin
            exp1_valid <= 1'b0;
            exp2_valid <= 1'b0;
        end else begin
            exp1_valid   <= fu_valid & ~flush;
            exp2_valid   <= exp1_valid & ~flush;
            killed_count <= killed_count + (flush ? int'(fu_valid) + int'(exp1_valid) : 0);
            seen_count   <= seen_count + int'(cdb_en);
        end
        exp1 <= cur_exp;
        exp2 <= exp1;
    end

    cdb_en_expected: assert property (@(posedge clk) disable iff (!n_rst)
        cdb_en == exp2_valid)
    else begin
        errors++;
        $display("ERROR: in %s the CDB enable was %b while %b was expected",
                 test_name, $sampled(cdb_en), $sampled(exp2_valid));
    end

    // Fields print as data addr tag redirect
    cdb_fields_match: assert property (@(posedge clk) disable iff (!n_rst)
        exp2_valid && cdb_en |-> {cdb_data, cdb_addr, cdb_tag, cdb_redirect} == exp2)
    else begin
        errors++;
        $display("MISMATCH %s: expected %h %h %0d %b, actual %h %h %0d %b", test_name,
                 $sampled(exp2.data), $sampled(exp2.addr), $sampled(exp2.tag),
                 $sampled(exp2.redirect), $sampled(cdb_data), $sampled(cdb_addr),
                 $sampled(cdb_tag), $sampled(cdb_redirect));
    end

    // Result rules applied straight to the raw instruction word
    task automatic model_result(input procyon_opcode_t opcode, input procyon_data_t insn,
                                input procyon_addr_t iaddr, input procyon_data_t a,
                                input procyon_data_t b, output ieu_ex_t res);
        procyon_data_t imm_i;
        procyon_data_t imm_j;
        procyon_data_t imm_b;
        procyon_data_t rhs;
        logic          taken;
        imm_i = {{20{insn[31]}}, insn[31:20]};
        imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        rhs   = (opcode == OPCODE_OPIMM) ? imm_i : b;
        taken = 1'b0;
        res   = '0;
        res.addr = iaddr;
        case (opcode)
            OPCODE_LUI:   res.data = {insn[31:12], 12'h000};
            OPCODE_AUIPC: res.data = iaddr + {insn[31:12], 12'h000};
            OPCODE_JAL, OPCODE_JALR: begin
                res.data     = iaddr + 32'd4;
                res.redirect = 1'b1;
                res.addr     = (opcode == OPCODE_JAL) ? iaddr + imm_j : (a + imm_i) & ~32'd1;
            end
            OPCODE_BRANCH: begin
                case (insn[14:12])
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                res.redirect = taken;
                res.addr     = taken ? iaddr + imm_b : iaddr + 32'd4;
            end
            default: begin
                case (insn[14:12])
                    3'd0: res.data = (opcode == OPCODE_OP && insn[30]) ? a - rhs : a + rhs;
                    3'd1: res.data = a << rhs[4:0];
                    3'd2: res.data = {31'b0, $signed(a) < $signed(rhs)};
                    3'd3: res.data = {31'b0, a < rhs};
                    3'd4: res.data = a ^ rhs;
                    3'd5: res.data = insn[30] ? procyon_data_t'($signed(a) >>> rhs[4:0])
                                              : a >> rhs[4:0];
                    3'd6: res.data = a | rhs;
                    default: res.data = a & rhs;
                endcase
            end
        endcase
    endtask

    // Legal OP or OPIMM word with funct3 from i and the form switching every 8
    function automatic procyon_data_t alu_insn(input int i);
        procyon_data_t insn;
        logic [2:0]    f3;
        logic          alt;
        insn = $urandom;
        f3   = 3'(i);
        alt  = 1'($urandom);
        insn[14:12] = f3;
        if ((i / 8) % 2 == 0) begin
            insn[31:25] = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0};
            insn[6:0]   = OPCODE_OP;
        end else begin
            // Shift immediates keep the upper bits as funct7
            if (f3 == 3'd1 || f3 == 3'd5) begin
                insn[31:25] = {1'b0, alt && (f3 == 3'd5), 5'b0};
            end
            insn[6:0] = OPCODE_OPIMM;
        end
        return insn;
    endfunction

    // Full range words mixed with small values around zero
    function automatic procyon_data_t rand_word();
        return ($urandom % 2) ? $urandom : $urandom % 16 - 8;
    endfunction

    task automatic issue_insn(input procyon_data_t insn, input procyon_data_t a,
                              input procyon_data_t b);
        fu_valid  = 1'b1;
        fu_opcode = procyon_opcode_t'(insn[6:0]);
        fu_insn   = insn;
        fu_iaddr  = $urandom & 32'hffff_fffc;
        fu_src_a  = a;
        fu_src_b  = b;
        fu_tag    = tag_ctr;
        tag_ctr   = tag_ctr + 1'b1;
        model_result(fu_opcode, insn, fu_iaddr, a, b, cur_exp);
        cur_exp.tag = fu_tag;
        issued_count++;
        @(posedge clk);
        #2;
    endtask

    // Idle the issue port until every surviving instruction has left the CDB
    task automatic wait_results(input int limit);
        int cycles;
        cycles   = 0;
        fu_valid = 1'b0;
        while (seen_count + killed_count != issued_count && cycles < limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (seen_count + killed_count != issued_count) begin
            errors++;
            $display("ERROR: %s results still missing after %0d cycles", test_name, limit);
        end
    endtask

    initial begin
        procyon_data_t insn;
        procyon_data_t a;
        procyon_data_t b;
        void'($urandom(32'ha733));
        clk       = 1'b0;
        n_rst     = 1'b0;
        flush     = 1'b0;
        fu_valid  = 1'b0;
        fu_opcode = OPCODE_OP;
        fu_iaddr  = '0;
        fu_insn   = '0;
        fu_src_a  = '0;
        fu_src_b  = '0;
        fu_tag    = '0;
        cur_exp   = '0;
        repeat (4) @(posedge clk);
        #2;
        n_rst = 1'b1;
        // Nothing issued yet so the CDB has to stay idle
        repeat (5) @(posedge clk);
        #2;

        test_name = "alu";
        for (int i = 0; i < 128; i++) begin
            issue_insn(alu_insn(i), rand_word(), rand_word());
        end
        wait_results(10);

        test_name = "upper";
        for (int i = 0; i < 16; i++) begin
            insn = $urandom;
            insn[6:0] = (i % 2) ? OPCODE_LUI : OPCODE_AUIPC;
            issue_insn(insn, rand_word(), rand_word());
        end
        wait_results(10);

        test_name = "jump";
        for (int i = 0; i < 16; i++) begin
            insn = $urandom;
            insn[14:12] = 3'd0;
            insn[6:0] = (i % 2) ? OPCODE_JAL : OPCODE_JALR;
            issue_insn(insn, $urandom, rand_word());
        end
        wait_results(10);

        // Pairs run equal, less, greater, then with differing signs both ways
        test_name = "branch";
        for (int f = 0; f < 8; f++) begin
            for (int p = 0; p < 5 && f != 2 && f != 3; p++) begin
                insn = $urandom;
                insn[14:12] = 3'(f);
                insn[6:0] = OPCODE_BRANCH;
                a = $urandom & 32'h3fff_ffff;
                b = (p == 0) ? a : a + 32'd1 + ($urandom % 1000);
                if (p >= 3) begin
                    b[31] = 1'b1;
                end
                if (p == 2 || p == 4) begin
                    issue_insn(insn, b, a);
                end else begin
                    issue_insn(insn, a, b);
                end
            end
        end
        wait_results(10);

        // First round flushes along with an issue and the second with only the pipe busy
        test_name = "flush";
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < 3; j++) begin
                issue_insn(alu_insn(j), rand_word(), rand_word());
            end
            flush = 1'b1;
            if (k == 0) begin
                issue_insn(alu_insn(5), rand_word(), rand_word());
            end else begin
                fu_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            flush = 1'b0;
            for (int j = 0; j < 4; j++) begin
                issue_insn(alu_insn(j + 8), rand_word(), rand_word());
            end
            wait_results(10);
        end

        test_name = "burst";
        for (int i = 0; i < 32; i++) begin
            issue_insn(alu_insn(int'($urandom % 16)), rand_word(), rand_word());
        end
        wait_results(10);

        $display("Issued %0d, on CDB %0d, flushed %0d, errors %0d",
                 issued_count, seen_count, killed_count, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: procyon_ieu.f
+incdir+hw
hw/procyon_types.sv
hw/ieu_pkg.sv
hw/ieu_stage_if.sv
hw/ieu_id.sv
hw/ieu_ex.sv
hw/ieu.sv
verification/ieu_tb.sv

// File: Makefile
# Verilator lint and simulation of the integer execution unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f procyon_ieu.f --top-module ieu_tb

obj_dir/ieu_tb: procyon_ieu.f hw/*.sv hw/*.svh verification/*.sv
	verilator --binary --timing --assert -f procyon_ieu.f --top-module ieu_tb -o ieu_tb

sim: obj_dir/ieu_tb
	./obj_dir/ieu_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
